// File: rx_fifo_pkg.sv
// Shared constants for the RX datapath FIFO
// Mode codes, word bit map and field widths

package rx_fifo_pkg;

   // ******************************
   // Widths
   // ******************************
   localparam int WORD_W     = 40;        // One FIFO word
   localparam int OUT_W      = 2 * WORD_W; // Fabric output holds a word pair
   localparam int MODE_W     = 3;
   localparam int ERR_CNT_W  = 4;         // Word-align error counter
   localparam int RD_DELAY_W = 3;         // Phase-comp read delay setting

   // ******************************
   // FIFO mode codes
   // ******************************
   // Unlisted codes fall back to basic generic
   localparam logic [MODE_W-1:0] MODE_PHCOMP = 3'b000; // Phase compensation
   localparam logic [MODE_W-1:0] MODE_INTL   = 3'b001; // Interlaken generic
   localparam logic [MODE_W-1:0] MODE_BASIC  = 3'b101; // Basic generic
   localparam logic [MODE_W-1:0] MODE_REG    = 3'b011; // Register bypass

   // ******************************
   // Incoming word bit map
   // ******************************
   localparam int MARKER_BIT    = 39;  // Word-align marker
   localparam int INTL_WREN_BIT = 38;  // Interlaken write enable
   localparam int DV_BIT        = 36;  // Gearbox data valid

   // Output word
   localparam int DV_OUT_BIT    = 79;  // Data valid overrides upper marker

endpackage

// File: rx_dv_extract.sv
// RX data-valid extraction
// Decodes per-word valid from the incoming word and stretches it over the pair
`timescale 1ns/1ps

module rx_dv_extract (
   input  logic                            rd_clk,
   input  logic                            rd_rst_n,
   input  logic [rx_fifo_pkg::WORD_W-1:0]  aib_rx_data,
   input  logic [rx_fifo_pkg::MODE_W-1:0]  mode,
   input  logic                            r_gb_dv_en,     // Gearbox valid in use
   input  logic                            wa_lock,        // Word-align lock
   output logic                            data_valid_in
);

   import rx_fifo_pkg::*;

   logic intl_mode;
   logic intl_wren;     // Interlaken enable or don't care
   logic dv_raw;        // This word alone qualifies
   logic dv_raw_q;      // Previous word qualified

   assign intl_mode = (mode == MODE_INTL);

   // Bit 38 only matters for Interlaken
   assign intl_wren = intl_mode ? aib_rx_data[INTL_WREN_BIT] : 1'b1;

   // Locked, no marker, gearbox valid set
   assign dv_raw = wa_lock
                 & ~aib_rx_data[MARKER_BIT]
                 & aib_rx_data[DV_BIT]
                 & intl_wren;

   always_ff @(posedge rd_clk or negedge rd_rst_n) begin
      if (!rd_rst_n) begin
         dv_raw_q <= 1'b0;
      end else begin
         dv_raw_q <= dv_raw;     // Stretch to the second word
      end
   end

   // Gearbox valid covers both words of a pair
   // Without it the lock alone qualifies
   assign data_valid_in = r_gb_dv_en ? (dv_raw | dv_raw_q) : wa_lock;

endmodule

// File: rx_fifo_mem.sv
// Single-clock RX FIFO of 40-bit words
// Pops a word pair per read and derives programmable threshold flags
`timescale 1ns/1ps

module rx_fifo_mem #(
   parameter int ADDR_W = 6                                 // Depth is 2**ADDR_W words
) (
   input  logic                            rd_clk,
   input  logic                            rd_rst_n,
   input  logic                            srst,           // Sync clear
   input  logic                            wr_en,
   input  logic [rx_fifo_pkg::WORD_W-1:0]  wr_data,
   input  logic                            rd_en,          // Pair read request
   input  logic [ADDR_W:0]                 r_empty,        // Empty threshold
   input  logic [ADDR_W:0]                 r_pempty,       // Partial empty threshold
   input  logic [ADDR_W:0]                 r_pfull,        // Partial full threshold
   input  logic [ADDR_W:0]                 r_full,         // Full threshold
   output logic                            rd_fire,        // Read accepted this edge
   output logic [rx_fifo_pkg::OUT_W-1:0]   rd_pair,        // {later, earlier}
   output logic                            rd_empty,
   output logic                            rd_pempty,
   output logic                            rd_pfull,
   output logic                            rd_full
);

   import rx_fifo_pkg::*;

   localparam logic [ADDR_W:0] DEPTH = {1'b1, {ADDR_W{1'b0}}};
   localparam logic [ADDR_W:0] TWO   = (ADDR_W + 1)'(2);    // Words per read

   // ******************************
   // Storage and pointers
   // ******************************
   logic [WORD_W-1:0] mem [2**ADDR_W];

   logic [ADDR_W-1:0] wr_ptr;
   logic [ADDR_W-1:0] rd_ptr;
   logic [ADDR_W-1:0] rd_ptr_nx;   // Second word of the pair
   logic [ADDR_W:0]   count;       // Words stored
   logic              wr_ok;       // Write accepted

   // Overflow guard: drop when all slots are taken
   assign wr_ok = wr_en && (count < DEPTH);

   // Underflow guard: a read needs a whole pair
   assign rd_fire = rd_en && (count >= TWO);

   assign rd_ptr_nx = rd_ptr + 1'b1;   // Wraps with the array

   always_ff @(posedge rd_clk) begin
      if (wr_ok) begin
         mem[wr_ptr] <= wr_data;
      end
   end

   // Later word sits in the upper half
   assign rd_pair = {mem[rd_ptr_nx], mem[rd_ptr]};

   always_ff @(posedge rd_clk or negedge rd_rst_n) begin
      if (!rd_rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else if (srst) begin
         wr_ptr <= '0;      // Drop everything stored
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_ok) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_fire) begin
            rd_ptr <= rd_ptr + 2'd2;
         end
         case ({wr_ok, rd_fire})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - TWO;
            2'b11:   count <= count - 1'b1;   // One in, two out
            default: count <= count;
         endcase
      end
   end

   // ******************************
   // Threshold flags
   // ******************************
   // Follow the registered count
   assign rd_empty  = (count <= r_empty);
   assign rd_pempty = (count <= r_pempty);
   assign rd_pfull  = (count >= r_pfull);
   assign rd_full   = (count >= r_full);

   // Pointer and count updates must agree over any sequence
   a_count_in_range : assert property (
      @(posedge rd_clk) disable iff (!rd_rst_n)
      count <= DEPTH
   );

endmodule

// File: rx_enable_ctrl.sv
// RX FIFO enable control
// Mode decode, phase-comp start and read delay, latency slip and sync clear
`timescale 1ns/1ps

module rx_enable_ctrl (
   input  logic                                rd_clk,
   input  logic                                rd_rst_n,
   input  logic [rx_fifo_pkg::MODE_W-1:0]      mode,
   input  logic                                data_valid_in,
   input  logic                                rd_en_ext,          // Fabric read request
   input  logic [rx_fifo_pkg::RD_DELAY_W-1:0]  r_phcomp_rd_delay,
   input  logic                                fifo_latency_adj,
   input  logic                                r_wr_adj_en,        // Slip a write
   input  logic                                r_rd_adj_en,        // Slip a read
   input  logic                                rd_align_clr,
   input  logic                                r_write_ctrl,
   output logic                                wr_en,
   output logic                                rd_en,
   output logic                                srst,
   output logic                                rd_align_clr_reg
);

   import rx_fifo_pkg::*;

   logic       phcomp_mode;
   logic       intl_mode;
   logic       reg_mode;
   logic       wr_start;       // First valid seen since clear
   logic       wr_start_d1;
   logic       phcomp_wren;    // Write start plus 2 cycles
   logic [5:0] rd_dly;         // phcomp_wren delayed 1..6 cycles
   logic       phcomp_rden;
   logic       adj_q;
   logic       adj_rise;
   logic       wr_sel;
   logic       rd_sel;

   assign phcomp_mode = (mode == MODE_PHCOMP);
   assign intl_mode   = (mode == MODE_INTL);
   assign reg_mode    = (mode == MODE_REG);

   // ******************************
   // Sync clear
   // ******************************
   always_ff @(posedge rd_clk or negedge rd_rst_n) begin
      if (!rd_rst_n) begin
         rd_align_clr_reg <= 1'b0;
      end else begin
         rd_align_clr_reg <= rd_align_clr;
      end
   end

   // Interlaken always clears, other modes only without write control
   assign srst = (intl_mode || !r_write_ctrl) && rd_align_clr_reg;

   // ******************************
   // Phase-comp start and delay
   // ******************************
   always_ff @(posedge rd_clk or negedge rd_rst_n) begin
      if (!rd_rst_n) begin
         wr_start    <= 1'b0;
         wr_start_d1 <= 1'b0;
         phcomp_wren <= 1'b0;
         rd_dly      <= '0;
      end else if (srst) begin
         wr_start    <= 1'b0;
         wr_start_d1 <= 1'b0;
         phcomp_wren <= 1'b0;
         rd_dly      <= '0;
      end else begin
         wr_start    <= wr_start || data_valid_in;   // Sticky until clear
         wr_start_d1 <= wr_start;
         phcomp_wren <= wr_start_d1;
         rd_dly      <= {rd_dly[4:0], phcomp_wren};
      end
   end

   // Read gap behind phcomp_wren
   always_comb begin
      case (r_phcomp_rd_delay)
         3'd3:    phcomp_rden = rd_dly[2];
         3'd4:    phcomp_rden = rd_dly[3];
         3'd5:    phcomp_rden = rd_dly[4];
         3'd6:    phcomp_rden = rd_dly[5];
         default: phcomp_rden = rd_dly[1];   // Minimum gap of 2
      endcase
   end

   // ******************************
   // Latency adjust slip
   // ******************************
   always_ff @(posedge rd_clk or negedge rd_rst_n) begin
      if (!rd_rst_n) begin
         adj_q <= 1'b0;
      end else begin
         adj_q <= fifo_latency_adj;
      end
   end

   assign adj_rise = fifo_latency_adj && !adj_q;   // First high cycle

   // Enable selection per mode
   // Register mode leaves the FIFO idle
   assign wr_sel = phcomp_mode ? (phcomp_wren && data_valid_in) :
                   reg_mode    ? 1'b0 : data_valid_in;
   assign rd_sel = phcomp_mode ? phcomp_rden :
                   reg_mode    ? 1'b0 : rd_en_ext;

   assign wr_en = wr_sel && !(r_wr_adj_en && adj_rise);
   assign rd_en = rd_sel && !(r_rd_adj_en && adj_rise);

   // Reads never start ahead of the write side
   a_rden_after_wren : assert property (
      @(posedge rd_clk) disable iff (!rd_rst_n)
      phcomp_rden |-> phcomp_wren
   );

endmodule

// File: rx_out_stage.sv
// RX output register with register-mode bypass
// Also tracks align_done and counts word-align errors
`timescale 1ns/1ps

module rx_out_stage (
   input  logic                               rd_clk,
   input  logic                               rd_rst_n,
   input  logic                               srst,
   input  logic [rx_fifo_pkg::MODE_W-1:0]     mode,
   input  logic [rx_fifo_pkg::WORD_W-1:0]     aib_rx_data,
   input  logic                               rd_fire,     // Pair popped this edge
   input  logic [rx_fifo_pkg::OUT_W-1:0]      rd_pair,
   input  logic                               r_wa_en,     // Word-align checking on
   output logic [rx_fifo_pkg::OUT_W-1:0]      pld_rx_data,
   output logic                               data_valid_out,
   output logic                               align_done,
   output logic                               wa_error,
   output logic [rx_fifo_pkg::ERR_CNT_W-1:0]  wa_error_cnt
);

   import rx_fifo_pkg::*;

   logic             reg_mode;
   logic [OUT_W-1:0] data_q;     // Stored pair
   logic             rd_seen;    // Sticky read since clear

   assign reg_mode = (mode == MODE_REG);

   // ******************************
   // Output register
   // ******************************
   always_ff @(posedge rd_clk or negedge rd_rst_n) begin
      if (!rd_rst_n) begin
         data_q         <= '0;
         data_valid_out <= 1'b0;
      end else if (srst) begin
         data_q         <= '0;
         data_valid_out <= 1'b0;
      end else if (rd_fire) begin
         data_q         <= rd_pair;
         data_valid_out <= 1'b1;
      end else if (reg_mode) begin
         data_q         <= {{WORD_W{1'b0}}, aib_rx_data};   // Bypass the FIFO
         data_valid_out <= 1'b1;
      end else begin
         data_valid_out <= 1'b0;    // Hold data, drop valid
      end
   end

   // Valid replaces the upper marker bit
   assign pld_rx_data = {data_valid_out, data_q[DV_OUT_BIT-1:0]};

   // ******************************
   // Word-align status
   // ******************************
   // Lower marker set or upper marker missing
   assign wa_error = data_valid_out && r_wa_en
                   && (data_q[MARKER_BIT] || !data_q[DV_OUT_BIT]);

   always_ff @(posedge rd_clk or negedge rd_rst_n) begin
      if (!rd_rst_n) begin
         wa_error_cnt <= '0;
         rd_seen      <= 1'b0;
      end else if (srst) begin
         wa_error_cnt <= '0;
         rd_seen      <= 1'b0;
      end else begin
         if (wa_error && (wa_error_cnt != '1)) begin
            wa_error_cnt <= wa_error_cnt + 1'b1;   // Saturate at max
         end
         rd_seen <= rd_seen || rd_fire;
      end
   end

   assign align_done = r_wa_en && rd_seen;

   // Saturated count only leaves max through a clear
   a_cnt_no_wrap : assert property (
      @(posedge rd_clk) disable iff (!rd_rst_n)
      (wa_error_cnt == '1 && !srst) |=> (wa_error_cnt != '0)
   );

endmodule

// File: rx_datapath_top.sv
// RX datapath FIFO top level
// Valid extraction, enable control, FIFO storage and output stage
`timescale 1ns/1ps

module rx_datapath_top #(
   parameter int ADDR_W = 6                                   // FIFO depth 2**ADDR_W
) (
   input  logic                                rd_clk,
   input  logic                                rd_rst_n,
   input  logic [rx_fifo_pkg::WORD_W-1:0]      aib_rx_data,
   input  logic [rx_fifo_pkg::MODE_W-1:0]      mode,
   input  logic                                r_gb_dv_en,
   input  logic                                wa_lock,
   input  logic                                rd_en,         // Fabric read request
   input  logic [ADDR_W:0]                     r_empty,
   input  logic [ADDR_W:0]                     r_pempty,
   input  logic [ADDR_W:0]                     r_pfull,
   input  logic [ADDR_W:0]                     r_full,
   input  logic [rx_fifo_pkg::RD_DELAY_W-1:0]  r_phcomp_rd_delay,
   input  logic                                fifo_latency_adj,
   input  logic                                r_wr_adj_en,
   input  logic                                r_rd_adj_en,
   input  logic                                rd_align_clr,
   input  logic                                r_write_ctrl,
   input  logic                                r_wa_en,
   output logic [rx_fifo_pkg::OUT_W-1:0]       pld_rx_data,
   output logic                                data_valid_out,
   output logic                                rd_empty,
   output logic                                rd_pempty,
   output logic                                rd_pfull,
   output logic                                rd_full,
   output logic                                align_done,
   output logic                                wa_error,
   output logic [rx_fifo_pkg::ERR_CNT_W-1:0]   wa_error_cnt,
   output logic                                rd_align_clr_reg
);

   import rx_fifo_pkg::*;

   logic             data_valid_in;
   logic             fifo_wr_en;    // After mode select and slip
   logic             fifo_rd_en;
   logic             srst;
   logic             rd_fire;
   logic [OUT_W-1:0] rd_pair;

   // Per-word valid
   rx_dv_extract u_dv_extract (
      .rd_clk        (rd_clk),
      .rd_rst_n      (rd_rst_n),
      .aib_rx_data   (aib_rx_data),
      .mode          (mode),
      .r_gb_dv_en    (r_gb_dv_en),
      .wa_lock       (wa_lock),
      .data_valid_in (data_valid_in)
   );

   rx_enable_ctrl u_enable_ctrl (
      .rd_clk            (rd_clk),
      .rd_rst_n          (rd_rst_n),
      .mode              (mode),
      .data_valid_in     (data_valid_in),
      .rd_en_ext         (rd_en),
      .r_phcomp_rd_delay (r_phcomp_rd_delay),
      .fifo_latency_adj  (fifo_latency_adj),
      .r_wr_adj_en       (r_wr_adj_en),
      .r_rd_adj_en       (r_rd_adj_en),
      .rd_align_clr      (rd_align_clr),
      .r_write_ctrl      (r_write_ctrl),
      .wr_en             (fifo_wr_en),
      .rd_en             (fifo_rd_en),
      .srst              (srst),
      .rd_align_clr_reg  (rd_align_clr_reg)
   );

   // Word storage
   rx_fifo_mem #(
      .ADDR_W (ADDR_W)
   ) u_fifo_mem (
      .rd_clk    (rd_clk),
      .rd_rst_n  (rd_rst_n),
      .srst      (srst),
      .wr_en     (fifo_wr_en),
      .wr_data   (aib_rx_data),
      .rd_en     (fifo_rd_en),
      .r_empty   (r_empty),
      .r_pempty  (r_pempty),
      .r_pfull   (r_pfull),
      .r_full    (r_full),
      .rd_fire   (rd_fire),
      .rd_pair   (rd_pair),
      .rd_empty  (rd_empty),
      .rd_pempty (rd_pempty),
      .rd_pfull  (rd_pfull),
      .rd_full   (rd_full)
   );

   rx_out_stage u_out_stage (
      .rd_clk         (rd_clk),
      .rd_rst_n       (rd_rst_n),
      .srst           (srst),
      .mode           (mode),
      .aib_rx_data    (aib_rx_data),
      .rd_fire        (rd_fire),
      .rd_pair        (rd_pair),
      .r_wa_en        (r_wa_en),
      .pld_rx_data    (pld_rx_data),
      .data_valid_out (data_valid_out),
      .align_done     (align_done),
      .wa_error       (wa_error),
      .wa_error_cnt   (wa_error_cnt)
   );

endmodule

// File: tb_rx_datapath.sv
// Testbench for the RX datapath FIFO
// Random stimulus checked every cycle against a queue model
`timescale 1ns/1ps

module tb_rx_datapath;

   import rx_fifo_pkg::*;

   localparam int DEPTH = 64;

   logic                  rd_clk;
   logic                  rd_rst_n;
   logic [WORD_W-1:0]     aib_rx_data;
   logic [MODE_W-1:0]     mode;
   logic                  r_gb_dv_en, wa_lock, rd_en;
   logic [6:0]            r_empty, r_pempty, r_pfull, r_full;
   logic [RD_DELAY_W-1:0] r_phcomp_rd_delay;
   logic                  fifo_latency_adj, r_wr_adj_en, r_rd_adj_en;
   logic                  rd_align_clr, r_write_ctrl, r_wa_en;
   logic [OUT_W-1:0]      pld_rx_data;
   logic                  data_valid_out, rd_empty, rd_pempty, rd_pfull, rd_full;
   logic                  align_done, wa_error, rd_align_clr_reg;
   logic [ERR_CNT_W-1:0]  wa_error_cnt;

   // Stimulus knobs in percent per cycle
   int     marker_pct, dv_pct, intl_pct, lock_pct, rd_pct, adj_pct;
   logic   clr_req;
   integer seed;
   int     checks, errors, cyc, start_cyc, dropped, slips, err_total;

   // ******************************
   // Reference model state
   // ******************************
   logic [WORD_W-1:0] m_q [$];      // Stored words, oldest first
   logic              m_raw_q, m_wr_start, m_wr_start_d1, m_phcomp_wren;
   logic [5:0]        m_rd_dly;
   logic              m_adj_q, m_clr_reg, m_dv, m_rd_seen;
   logic [OUT_W-1:0]  m_data;
   logic [3:0]        m_cnt;

   rx_datapath_top #(.ADDR_W(6)) DUT (.*);

   initial begin
      rd_clk = 1'b0;
      forever #20 rd_clk = ~rd_clk;
   end

   function automatic int rnd(input int n);
      rnd = ($random(seed) & 32'h7fffffff) % n;
   endfunction

   function automatic logic chance(input int pct);
      chance = (rnd(100) < pct);
   endfunction

   task automatic compare_value(input string what, input logic [OUT_W-1:0] got,
                                input logic [OUT_W-1:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Mismatch at %0t ns: %s expected %h got %h", $time, what, exp, got);
      end
   endtask

   // New random inputs 2 ns after the edge
   task automatic drive_inputs();
      logic [63:0] d;
      d = {$random(seed), $random(seed)};
      d[MARKER_BIT]    = chance(marker_pct);
      d[DV_BIT]        = chance(dv_pct);
      d[INTL_WREN_BIT] = chance(intl_pct);
      aib_rx_data      = d[WORD_W-1:0];
      wa_lock          = chance(lock_pct);
      rd_en            = chance(rd_pct);
      fifo_latency_adj = chance(adj_pct);
      rd_align_clr     = clr_req;       // One-cycle pulse
      clr_req          = 1'b0;
   endtask

   // One clock of model update from pre-edge inputs, compare and drive
   task automatic step();
      logic raw, dvin, srst_m, rise, wsel, rsel, we, re, fire, wok, werr;
      int   n;
      @(posedge rd_clk);
      #1;
      cyc++;
      raw    = wa_lock && !aib_rx_data[MARKER_BIT] && aib_rx_data[DV_BIT]
               && (mode != MODE_INTL || aib_rx_data[INTL_WREN_BIT]);
      dvin   = r_gb_dv_en ? (raw || m_raw_q) : wa_lock;
      srst_m = (mode == MODE_INTL || !r_write_ctrl) && m_clr_reg;
      rise   = fifo_latency_adj && !m_adj_q;
      n      = (r_phcomp_rd_delay >= 3 && r_phcomp_rd_delay <= 6) ? r_phcomp_rd_delay : 2;
      if (mode == MODE_PHCOMP) begin
         wsel = m_phcomp_wren && dvin;
         rsel = m_rd_dly[n-1];             // phcomp_wren N cycles late
      end else if (mode == MODE_REG) begin
         wsel = 1'b0;
         rsel = 1'b0;
      end else begin
         wsel = dvin;
         rsel = rd_en;
      end
      we   = wsel && !(r_wr_adj_en && rise);
      re   = rsel && !(r_rd_adj_en && rise);
      if (rise && ((r_wr_adj_en && wsel) || (r_rd_adj_en && rsel))) slips++;
      fire = re && (m_q.size() >= 2);
      wok  = we && (m_q.size() < DEPTH);   // Pre-edge count
      if (we && !wok) dropped++;
      werr = m_dv && r_wa_en && (m_data[MARKER_BIT] || !m_data[DV_OUT_BIT]);
      m_raw_q   = raw;
      m_adj_q   = fifo_latency_adj;
      m_clr_reg = rd_align_clr;
      if (srst_m) begin
         m_q.delete();
         {m_wr_start, m_wr_start_d1, m_phcomp_wren, m_dv, m_rd_seen} = '0;
         m_rd_dly  = '0;
         m_data    = '0;
         m_cnt     = '0;
         err_total = 0;
      end else begin
         if (!m_wr_start && dvin) start_cyc = cyc;
         m_rd_dly      = {m_rd_dly[4:0], m_phcomp_wren};
         m_phcomp_wren = m_wr_start_d1;
         m_wr_start_d1 = m_wr_start;
         m_wr_start    = m_wr_start || dvin;
         if (werr) err_total++;
         if (werr && m_cnt != 4'd15) m_cnt = m_cnt + 1'b1;
         m_rd_seen = m_rd_seen || fire;
         if (fire) begin
            m_data = {m_q[1], m_q[0]};       // Later word on top
            void'(m_q.pop_front());
            void'(m_q.pop_front());
            m_dv = 1'b1;
         end else if (mode == MODE_REG) begin
            m_data = {{WORD_W{1'b0}}, aib_rx_data};
            m_dv   = 1'b1;
         end else begin
            m_dv = 1'b0;
         end
         if (wok) m_q.push_back(aib_rx_data);
      end
      compare_value("data_valid_out", data_valid_out, m_dv);
      compare_value("pld_rx_data", pld_rx_data, {m_dv, m_data[DV_OUT_BIT-1:0]});
      compare_value("rd_empty", rd_empty, m_q.size() <= r_empty);
      compare_value("rd_pempty", rd_pempty, m_q.size() <= r_pempty);
      compare_value("rd_pfull", rd_pfull, m_q.size() >= r_pfull);
      compare_value("rd_full", rd_full, m_q.size() >= r_full);
      compare_value("wa_error", wa_error,
                    m_dv && r_wa_en && (m_data[MARKER_BIT] || !m_data[DV_OUT_BIT]));
      compare_value("wa_error_cnt", wa_error_cnt, m_cnt);
      compare_value("align_done", align_done, r_wa_en && m_rd_seen);
      compare_value("rd_align_clr_reg", rd_align_clr_reg, m_clr_reg);
      #1;
      drive_inputs();
   endtask

   // Pulse, register, then srst edge
   task automatic clear_fifo();
      clr_req = 1'b1;
      repeat (3) step();
   endtask

   task automatic print_result(input string name, input int err_before);
      $display("Test %s: %s (%0d errors)", name,
               (errors == err_before) ? "pass" : "fail", errors - err_before);
   endtask

   // ******************************
   // Tests
   // ******************************
   task automatic generic_traffic();
      int e0;
      e0 = errors;
      {marker_pct, dv_pct, intl_pct, lock_pct, rd_pct} = {32'd10, 32'd70, 32'd70, 32'd90, 32'd50};
      repeat (8) begin
         mode         = chance(50) ? MODE_INTL : MODE_BASIC;
         r_gb_dv_en   = chance(50);
         r_write_ctrl = chance(50);   // Blocks the clear in basic mode
         clr_req      = chance(50);
         r_empty      = rnd(8);
         r_pempty     = 8 + rnd(16);
         r_pfull      = 32 + rnd(24);
         r_full       = 56 + rnd(9);
         repeat (50) step();
      end
      r_write_ctrl = 1'b0;
      print_result("generic modes", e0);
   endtask

   task automatic overflow_underflow();
      int e0, t;
      e0 = errors;
      {mode, r_gb_dv_en, lock_pct, rd_pct} = {MODE_BASIC, 1'b0, 32'd100, 32'd0};
      {r_empty, r_full} = {7'd0, 7'd64};
      clear_fifo();
      dropped = 0;
      t = 0;
      while (!rd_full && t < 200) begin
         step();
         t++;
      end
      if (!rd_full) begin
         errors++;
         $display("Timeout: FIFO never reported full");
      end
      repeat (20) step();                 // Writes into a full FIFO
      if (dropped == 0) begin
         errors++;
         $display("No write was dropped while the FIFO was full");
      end
      {lock_pct, rd_pct} = {32'd0, 32'd100};
      t = 0;
      while (!rd_empty && t < 60) begin
         step();
         t++;
      end
      if (!rd_empty) begin
         errors++;
         $display("Timeout: FIFO never drained to empty");
      end
      // Leave a single word behind
      {lock_pct, rd_pct} = {32'd100, 32'd0};
      step();
      {lock_pct, rd_pct} = {32'd0, 32'd100};
      repeat (10) begin
         step();
         compare_value("valid on underflow read", data_valid_out, 1'b0);
      end
      print_result("overflow and underflow", e0);
   endtask

   task automatic phcomp_delays();
      int e0, t, n;
      e0 = errors;
      {mode, r_gb_dv_en, lock_pct, rd_pct} = {MODE_PHCOMP, 1'b0, 32'd100, 32'd0};
      for (int dly = 0; dly < 8; dly++) begin
         r_phcomp_rd_delay = dly;
         n = (dly >= 3 && dly <= 6) ? dly : 2;
         clear_fifo();
         t = 0;
         while (!data_valid_out && t < 40) begin
            step();
            t++;
         end
         if (!data_valid_out) begin
            errors++;
            $display("Timeout: no phase-comp output with delay %0d", dly);
         end else if (cyc - start_cyc < 2 + n) begin
            errors++;
            $display("Mismatch at %0t ns: output %0d cycles after write start, min %0d",
                     $time, cyc - start_cyc, 2 + n);
         end
         repeat (20) step();
      end
      print_result("phase compensation", e0);
   endtask

   task automatic register_bypass();
      int          e0;
      logic [WORD_W-1:0] prev;
      e0   = errors;
      mode = MODE_REG;
      repeat (60) begin
         prev = aib_rx_data;
         step();
         compare_value("register bypass", pld_rx_data, {1'b1, {(WORD_W-1){1'b0}}, prev});
      end
      print_result("register mode", e0);
   endtask

   task automatic word_align_errors();
      int e0, t;
      e0 = errors;
      {mode, r_wa_en, marker_pct, lock_pct, rd_pct} = {MODE_BASIC, 1'b1, 32'd30, 32'd100, 32'd60};
      r_empty = 7'd0;
      clear_fifo();
      compare_value("align_done after clear", align_done, 1'b0);
      t = 0;
      while (!align_done && t < 20) begin
         step();
         t++;
      end
      if (!align_done) begin
         errors++;
         $display("Timeout: align_done never rose after reads");
      end
      repeat (200) step();
      compare_value("saturated error count", wa_error_cnt, (err_total > 15) ? 15 : err_total);
      lock_pct = 0;                       // No writes across the clear
      clear_fifo();
      compare_value("error count after clear", wa_error_cnt, 0);
      compare_value("align_done after clear", align_done, 1'b0);
      compare_value("empty after clear", rd_empty, 1'b1);
      print_result("word align and clear", e0);
   endtask

   task automatic latency_slips();
      int e0;
      e0 = errors;
      {mode, marker_pct, lock_pct, rd_pct, adj_pct} = {MODE_BASIC, 32'd10, 32'd80, 32'd50, 32'd25};
      slips = 0;
      repeat (6) begin
         r_wr_adj_en = chance(50);
         r_rd_adj_en = chance(50);
         repeat (50) step();
      end
      if (slips == 0) begin
         errors++;
         $display("No latency-adjust slip happened");
      end
      print_result("latency adjust", e0);
   endtask

   initial begin
      seed = 32'hf037a4aa;
      {checks, errors, cyc, start_cyc, dropped, slips, err_total} = '0;
      {marker_pct, dv_pct, intl_pct, lock_pct, rd_pct, adj_pct} = '0;
      clr_req           = 1'b0;
      aib_rx_data       = '0;
      mode              = MODE_BASIC;
      {r_gb_dv_en, wa_lock, rd_en, fifo_latency_adj} = 4'b0;
      {r_wr_adj_en, r_rd_adj_en, rd_align_clr, r_write_ctrl, r_wa_en} = 5'b0;
      {r_empty, r_pempty, r_pfull, r_full} = {7'd0, 7'd8, 7'd56, 7'd64};
      r_phcomp_rd_delay = '0;
      // Model starts from reset values
      m_q.delete();
      {m_raw_q, m_wr_start, m_wr_start_d1, m_phcomp_wren} = 4'b0;
      {m_adj_q, m_clr_reg, m_dv, m_rd_seen} = 4'b0;
      m_rd_dly = '0;
      m_data   = '0;
      m_cnt    = '0;
      rd_rst_n = 1'b0;
      repeat (5) @(posedge rd_clk);
      #2;
      rd_rst_n = 1'b1;
      generic_traffic();
      overflow_underflow();
      phcomp_delays();
      register_bypass();
      word_align_errors();
      latency_slips();
      $display("Checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

// File: project.f
rx_fifo_pkg.sv
rx_dv_extract.sv
rx_fifo_mem.sv
rx_enable_ctrl.sv
rx_out_stage.sv
rx_datapath_top.sv
tb_rx_datapath.sv

// File: Bender.yml
package:
  name: rx_datapath

sources:
  - rx_fifo_pkg.sv
  - rx_dv_extract.sv
  - rx_fifo_mem.sv
  - rx_enable_ctrl.sv
  - rx_out_stage.sv
  - rx_datapath_top.sv
  - target: test
    files:
      - tb_rx_datapath.sv
